// File: run.sh
#!/usr/bin/env bash
# Verilator build and run of the video mode testbench
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	--top-module tb_video_mode -f vlog.f -Mdir obj_dir -o tb_video_mode > "$LOG" 2>&1 \
	&& ./obj_dir/tb_video_mode >> "$LOG" 2>&1 \
	|| echo "Build or simulation exited with an error" >> "$LOG"
cat "$LOG"

grep -q "Verification failed" "$LOG" && exit 1
grep -q "Verification passed" "$LOG" || exit 1
exit 0

// File: source/mode_control.sv
`timescale 1ns/1ps

module mode_control (
	input  logic                 clk50m_bufg,
	input  logic                 rst_n,
	input  video_pkg::mode_t     mode_code,
	input  logic                 mode_load,
	output video_pkg::mode_t     mode,
	output logic                 restart,
	output video_pkg::clk_cfg_t  clk_cfg,
	output logic                 prog_go
);
	import video_pkg::*;

	logic [GO_W-1:0] go_cnt;  // Cycles left to the go strobe
	logic            go_busy;

	// Synth wants M and D minus one
	function automatic clk_cfg_t md(input int m, input int d);
		clk_cfg_t cfg;
		cfg.m = 8'(m - 1);
		cfg.d = 8'(d - 1);
		return cfg;
	endfunction

	assign restart = mode_load; // Raster restarts with the load

	////////////////////
	// Mode and M/D
	////////////////////
	always_ff @(posedge clk50m_bufg) begin
		if (!rst_n) begin
			mode    <= mode_hd720;
			clk_cfg <= md(PCLK_M_HD720, PCLK_D_HD720);
		end else if (mode_load) begin
			case (mode_code)
				mode_vga: begin
					mode    <= mode_vga;
					clk_cfg <= md(PCLK_M_VGA, PCLK_D_VGA);
				end
				mode_svga: begin
					mode    <= mode_svga;
					clk_cfg <= md(PCLK_M_SVGA, PCLK_D_SVGA);
				end
				mode_xga: begin
					mode    <= mode_xga;
					clk_cfg <= md(PCLK_M_XGA, PCLK_D_XGA);
				end
				mode_sxga: begin
					mode    <= mode_sxga;
					clk_cfg <= md(PCLK_M_SXGA, PCLK_D_SXGA);
				end
				mode_camera: begin
					mode    <= mode_camera;
					clk_cfg <= md(PCLK_M_CAMERA, PCLK_D_CAMERA);
				end
				default: begin // HD720 and any unused code
					mode    <= mode_hd720;
					clk_cfg <= md(PCLK_M_HD720, PCLK_D_HD720);
				end
			endcase
		end
	end

	////////////////////
	// Go strobe delay
	////////////////////
	always_ff @(posedge clk50m_bufg) begin
		if (!rst_n) begin
			go_cnt  <= '0;
			go_busy <= 1'b0;
			prog_go <= 1'b0;
		end else if (mode_load) begin // New load restarts the wait
			go_cnt  <= GO_W'(PROG_GO_DELAY - 1);
			go_busy <= 1'b1;
			prog_go <= 1'b0;
		end else begin
			prog_go <= go_busy && (go_cnt == GO_W'(1)); // Lands PROG_GO_DELAY after load
			if (go_busy) begin
				go_cnt  <= go_cnt - 1'b1;
				go_busy <= (go_cnt != GO_W'(1));
			end
		end
	end

endmodule

// File: source/mode_switch_debounce.sv
`timescale 1ns/1ps

module mode_switch_debounce (
	input  logic               clk50m_bufg,
	input  logic               rst_n,
	input  logic [3:0]         sw,
	output video_pkg::mode_t   mode_code,
	output logic               mode_load
);
	import video_pkg::*;

	logic [3:0]       sw_meta;   // First sync flop
	logic [3:0]       sw_sync;   // Safe to use
	logic [3:0]       cand;      // Code being timed
	logic [DEB_W-1:0] stab_cnt;  // Cycles cand has held
	logic             loaded;    // Something accepted since reset
	logic             stable;

	assign stable = (sw_sync == cand) && (stab_cnt == DEB_W'(DEBOUNCE_CYCLES - 1));

	always_ff @(posedge clk50m_bufg) begin
		if (!rst_n) begin
			sw_meta   <= '0;
			sw_sync   <= '0;
			cand      <= '0;
			stab_cnt  <= '0;
			loaded    <= 1'b0;
			mode_code <= mode_hd720;
			mode_load <= 1'b0;
		end else begin
			sw_meta   <= sw;
			sw_sync   <= sw_meta;
			mode_load <= 1'b0; // Single cycle pulse
			if (sw_sync != cand) begin // Bounce restarts the timing
				cand     <= sw_sync;
				stab_cnt <= '0;
			end else if (!stable) begin
				stab_cnt <= stab_cnt + 1'b1;
			end
			// Only a new code, or the very first one, is passed on
			if (stable && (!loaded || (cand != mode_code))) begin
				mode_code <= mode_t'(cand);
				mode_load <= 1'b1;
				loaded    <= 1'b1;
			end
		end
	end

endmodule

// File: source/raster_timing.sv
`timescale 1ns/1ps

module raster_timing (
	input  logic                    clk50m_bufg,
	input  logic                    rst_n,
	input  logic                    restart,
	input  video_pkg::timing_t      timing,
	output video_pkg::video_sync_t  video
);
	import video_pkg::*;

	logic [CNT_W-1:0] hcount;
	logic [CNT_W-1:0] vcount;
	logic             h_wrap;    // Last pixel of the line
	logic             hblnk;
	logic             vblnk;
	logic             hsync_raw;
	logic             vsync_raw;
	video_sync_t      video_q;   // First output stage

	assign h_wrap = (hcount >= timing.heblnk);

	////////////////////
	// Counters
	////////////////////
	always_ff @(posedge clk50m_bufg) begin
		if (!rst_n || restart) begin
			hcount <= '0;
			vcount <= '0;
		end else if (h_wrap) begin
			hcount <= '0;
			if (vcount >= timing.veblnk) // End of frame
				vcount <= '0;
			else
				vcount <= vcount + 1'b1;
		end else begin
			hcount <= hcount + 1'b1;
		end
	end

	// Raw flags are active high
	assign hblnk     = (hcount > timing.hsblnk);
	assign vblnk     = (vcount > timing.vsblnk);
	assign hsync_raw = (hcount > timing.hssync) && (hcount <= timing.hesync);
	assign vsync_raw = (vcount > timing.vssync) && (vcount <= timing.vesync);

	////////////////////
	// Output stage
	////////////////////
	// Two registers for every output so sync and de stay lined up
	always_ff @(posedge clk50m_bufg) begin
		if (!rst_n) begin
			video_q <= '0;
			video   <= '0;
		end else begin
			video_q.hsync <= hsync_raw ^ timing.sync_neg; // Polarity per format
			video_q.vsync <= vsync_raw ^ timing.sync_neg;
			video_q.de    <= !hblnk && !vblnk;
			video         <= video_q; // Counter plus two
		end
	end

endmodule

// File: source/timing_table.sv
`timescale 1ns/1ps

module timing_table (
	input  video_pkg::mode_t    mode,
	output video_pkg::timing_t  timing
);
	import video_pkg::*;

	// Porch widths to cumulative counter thresholds
	function automatic timing_t calc(
		input int   h_pix,
		input int   h_fp,
		input int   h_sw,
		input int   h_bp,
		input int   v_pix,
		input int   v_fp,
		input int   v_sw,
		input int   v_bp,
		input logic neg
	);
		timing_t t;
		t.hsblnk   = CNT_W'(h_pix - 1);
		t.hssync   = CNT_W'(h_pix - 1 + h_fp);
		t.hesync   = CNT_W'(h_pix - 1 + h_fp + h_sw);
		t.heblnk   = CNT_W'(h_pix - 1 + h_fp + h_sw + h_bp); // Line total minus one
		t.vsblnk   = CNT_W'(v_pix - 1);
		t.vssync   = CNT_W'(v_pix - 1 + v_fp);
		t.vesync   = CNT_W'(v_pix - 1 + v_fp + v_sw);
		t.veblnk   = CNT_W'(v_pix - 1 + v_fp + v_sw + v_bp);
		t.sync_neg = neg;
		return t;
	endfunction

	always_comb begin
		case (mode)
			mode_vga: timing = calc(H_PIX_VGA, H_FP_VGA, H_SW_VGA, H_BP_VGA,
				V_PIX_VGA, V_FP_VGA, V_SW_VGA, V_BP_VGA, 1'b1); // Negative
			mode_svga: timing = calc(H_PIX_SVGA, H_FP_SVGA, H_SW_SVGA, H_BP_SVGA,
				V_PIX_SVGA, V_FP_SVGA, V_SW_SVGA, V_BP_SVGA, 1'b0);
			mode_xga: timing = calc(H_PIX_XGA, H_FP_XGA, H_SW_XGA, H_BP_XGA,
				V_PIX_XGA, V_FP_XGA, V_SW_XGA, V_BP_XGA, 1'b1); // Negative
			mode_sxga: timing = calc(H_PIX_SXGA, H_FP_SXGA, H_SW_SXGA, H_BP_SXGA,
				V_PIX_SXGA, V_FP_SXGA, V_SW_SXGA, V_BP_SXGA, 1'b0);
			mode_camera: timing = calc(H_PIX_CAMERA, H_FP_CAMERA, H_SW_CAMERA, H_BP_CAMERA,
				V_PIX_CAMERA, V_FP_CAMERA, V_SW_CAMERA, V_BP_CAMERA, 1'b0);
			default: timing = calc(H_PIX_HD720, H_FP_HD720, H_SW_HD720, H_BP_HD720,
				V_PIX_HD720, V_FP_HD720, V_SW_HD720, V_BP_HD720, 1'b0); // 720p
		endcase
	end

endmodule

// File: source/video_mode_top.sv
`timescale 1ns/1ps

module video_mode_top (
	input  logic                    clk50m_bufg,
	input  logic                    rst_n,
	input  logic [3:0]              sw,
	output video_pkg::video_sync_t  video,
	output video_pkg::clk_cfg_t     clk_cfg,
	output logic                    prog_go
);
	import video_pkg::*;

	mode_t   mode_code;  // Accepted switch code
	logic    mode_load;
	mode_t   mode;       // Mapped and registered
	logic    restart;
	timing_t timing;

	mode_switch_debounce u_debounce (
		.clk50m_bufg (clk50m_bufg),
		.rst_n       (rst_n),
		.sw          (sw),
		.mode_code   (mode_code),
		.mode_load   (mode_load)
	);

	mode_control u_mode_control (
		.clk50m_bufg (clk50m_bufg),
		.rst_n       (rst_n),
		.mode_code   (mode_code),
		.mode_load   (mode_load),
		.mode        (mode),
		.restart     (restart),
		.clk_cfg     (clk_cfg),
		.prog_go     (prog_go)
	);

	timing_table u_timing_table (.mode(mode), .timing(timing)); // Combinational

	raster_timing u_raster (
		.clk50m_bufg (clk50m_bufg),
		.rst_n       (rst_n),
		.restart     (restart),
		.timing      (timing),
		.video       (video)
	);

endmodule

// File: source/video_pkg.sv
package video_pkg;

	////////////////////
	// Switch codes
	////////////////////
	typedef enum logic [3:0] {
		mode_vga    = 4'b0000,
		mode_svga   = 4'b0001,
		mode_hd720  = 4'b0010, // Also the fallback for unused codes
		mode_xga    = 4'b0011,
		mode_sxga   = 4'b1000,
		mode_camera = 4'b1001
	} mode_t;

	localparam int CNT_W = 11; // Raster counters reach 2047

	// Cumulative raster thresholds for one format
	typedef struct packed {
		logic [CNT_W-1:0] hsblnk; // Last active pixel
		logic [CNT_W-1:0] hssync; // Sync starts after this
		logic [CNT_W-1:0] hesync; // Last sync pixel
		logic [CNT_W-1:0] heblnk; // Line total minus one
		logic [CNT_W-1:0] vsblnk;
		logic [CNT_W-1:0] vssync;
		logic [CNT_W-1:0] vesync;
		logic [CNT_W-1:0] veblnk;
		logic             sync_neg; // 1 = active low sync
	} timing_t;

	// Pixel clock synth settings stored minus one
	typedef struct packed {
		logic [7:0] m;
		logic [7:0] d;
	} clk_cfg_t;

	typedef struct packed {
		logic hsync;
		logic vsync;
		logic de;
	} video_sync_t;

	////////////////////
	// Format geometry
	////////////////////
	// Active, front porch, sync width, back porch
	localparam int H_PIX_VGA = 640, H_FP_VGA = 16, H_SW_VGA = 96, H_BP_VGA = 48;
	localparam int V_PIX_VGA = 480, V_FP_VGA = 11, V_SW_VGA = 2, V_BP_VGA = 31;
	localparam int H_PIX_SVGA = 800, H_FP_SVGA = 40, H_SW_SVGA = 128, H_BP_SVGA = 88;
	localparam int V_PIX_SVGA = 600, V_FP_SVGA = 1, V_SW_SVGA = 4, V_BP_SVGA = 23;
	localparam int H_PIX_XGA = 1024, H_FP_XGA = 24, H_SW_XGA = 136, H_BP_XGA = 160;
	localparam int V_PIX_XGA = 768, V_FP_XGA = 3, V_SW_XGA = 6, V_BP_XGA = 29;
	localparam int H_PIX_HD720 = 1280, H_FP_HD720 = 110, H_SW_HD720 = 40, H_BP_HD720 = 220;
	localparam int V_PIX_HD720 = 720, V_FP_HD720 = 5, V_SW_HD720 = 5, V_BP_HD720 = 20;
	localparam int H_PIX_SXGA = 1280, H_FP_SXGA = 48, H_SW_SXGA = 112, H_BP_SXGA = 248;
	localparam int V_PIX_SXGA = 1024, V_FP_SXGA = 1, V_SW_SXGA = 3, V_BP_SXGA = 38;
	localparam int H_PIX_CAMERA = 1280, H_FP_CAMERA = 110, H_SW_CAMERA = 39, H_BP_CAMERA = 220;
	localparam int V_PIX_CAMERA = 720, V_FP_CAMERA = 4, V_SW_CAMERA = 4, V_BP_CAMERA = 22;

	////////////////////
	// Pixel clock M/D
	////////////////////
	localparam int PCLK_M_VGA = 2, PCLK_D_VGA = 4;           // 25 MHz
	localparam int PCLK_M_SVGA = 4, PCLK_D_SVGA = 5;         // 40 MHz
	localparam int PCLK_M_XGA = 13, PCLK_D_XGA = 10;         // 65 MHz
	localparam int PCLK_M_SXGA = 54, PCLK_D_SXGA = 25;       // 108 MHz
	localparam int PCLK_M_CAMERA = 135, PCLK_D_CAMERA = 91;
	localparam int PCLK_M_HD720 = 248, PCLK_D_HD720 = 167;   // 74.25 MHz

	// Control timing
	localparam int DEBOUNCE_CYCLES = 256;
	localparam int DEB_W = $clog2(DEBOUNCE_CYCLES);
	localparam int PROG_GO_DELAY = 16; // Load to synth go strobe
	localparam int GO_W = $clog2(PROG_GO_DELAY);

endpackage

// File: verif/tb_video_mode.sv
`timescale 1ns/1ps

////////////////////
// Run length and rise-to-rise spacing of one level
////////////////////
module pulse_meter (
	input  logic clk50m_bufg,
	input  logic rst_n,
	input  logic clr,          // Forget everything seen so far
	input  logic level,
	output int   width,        // Cycles high in the last full run
	output logic width_done,
	output int   period,       // Cycles between two rises
	output logic period_done
);
	logic level_q;
	logic rise_seen; // Runs before the first rise are partial
	int   high_cnt;
	int   per_cnt;

	always_ff @(posedge clk50m_bufg) begin
		level_q     <= level;
		width_done  <= 1'b0;
		period_done <= 1'b0;
		if (!rst_n || clr) begin
			rise_seen <= 1'b0;
			high_cnt  <= 0;
			per_cnt   <= 0;
		end else if (level && !level_q) begin // Rise
			rise_seen <= 1'b1;
			high_cnt  <= 1;
			per_cnt   <= 1;
			if (rise_seen) begin
				period      <= per_cnt;
				period_done <= 1'b1;
			end
		end else begin
			per_cnt  <= per_cnt + 1;
			high_cnt <= high_cnt + 1;
			if (!level && level_q && rise_seen) begin // Fall closes the run
				width      <= high_cnt;
				width_done <= 1'b1;
			end
		end
	end
endmodule

module tb_video_mode;
	import video_pkg::*;

	// Expected figures for one format
	typedef struct packed {
		int         pix;     // Active pixels
		int         hsw;     // Hsync width, cycles
		int         htotal;  // Line period
		int         vsw;     // Vsync width, lines
		int         vtotal;  // Lines per frame
		logic       neg;     // Active low sync
		logic [7:0] m;
		logic [7:0] d;
	} expect_t;

	// Two VGA frames take about 840k cycles and each other step a few thousand
	localparam int TIMEOUT_CYCLES = 2_000_000;

	logic        clk50m_bufg;
	logic        rst_n;
	logic [3:0]  sw;
	video_sync_t video;
	clk_cfg_t    clk_cfg;
	logic        prog_go;

	expect_t    want;             // Format the DUT should be in
	logic       hold_checks;      // High while a new format settles
	int         exp_gos = 0;      // prog_go pulses allowed so far
	int         go_count = 0;
	int         rst_cycles = 0;
	int         cycles = 0;
	int         line_count = 0;
	int         frame_count = 0;
	int         glitch_len;
	logic [3:0] glitch_code;

	logic hs_act;  // Sync at its active level
	logic vs_act;
	int   de_width;
	int   hs_width;
	int   hs_period;
	int   vs_width;
	int   vs_period;
	logic de_done;
	logic hs_done;
	logic hs_per_done;
	logic vs_done;
	logic vs_per_done;

	always #10 clk50m_bufg = ~clk50m_bufg; // 50 MHz

	video_mode_top dut (
		.clk50m_bufg (clk50m_bufg),
		.rst_n       (rst_n),
		.sw          (sw),
		.video       (video),
		.clk_cfg     (clk_cfg),
		.prog_go     (prog_go)
	);

	assign hs_act = video.hsync ^ want.neg;
	assign vs_act = video.vsync ^ want.neg;

	pulse_meter de_meter (.clk50m_bufg, .rst_n, .clr(hold_checks), .level(video.de),
		.width(de_width), .width_done(de_done), .period(), .period_done());
	pulse_meter hs_meter (.clk50m_bufg, .rst_n, .clr(hold_checks), .level(hs_act),
		.width(hs_width), .width_done(hs_done), .period(hs_period), .period_done(hs_per_done));
	pulse_meter vs_meter (.clk50m_bufg, .rst_n, .clr(hold_checks), .level(vs_act),
		.width(vs_width), .width_done(vs_done), .period(vs_period), .period_done(vs_per_done));

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Verification failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp_v);
		fail_run($sformatf("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp_v));
	endtask

	function automatic expect_t make_expect(input int h_pix, input int h_fp, input int h_sw,
		input int h_bp, input int v_pix, input int v_fp, input int v_sw, input int v_bp,
		input logic neg, input int m, input int d);
		expect_t e;
		e.pix    = h_pix;
		e.hsw    = h_sw;
		e.htotal = h_pix + h_fp + h_sw + h_bp; // Both porches plus sync
		e.vsw    = v_sw;
		e.vtotal = v_pix + v_fp + v_sw + v_bp;
		e.neg    = neg;
		e.m      = 8'(m - 1); // Synth takes M and D minus one
		e.d      = 8'(d - 1);
		return e;
	endfunction

	function automatic expect_t expect_for(input logic [3:0] code);
		expect_t e;
		case (code)
			mode_vga: e = make_expect(H_PIX_VGA, H_FP_VGA, H_SW_VGA, H_BP_VGA,
				V_PIX_VGA, V_FP_VGA, V_SW_VGA, V_BP_VGA, 1'b1, PCLK_M_VGA, PCLK_D_VGA);
			mode_svga: e = make_expect(H_PIX_SVGA, H_FP_SVGA, H_SW_SVGA, H_BP_SVGA,
				V_PIX_SVGA, V_FP_SVGA, V_SW_SVGA, V_BP_SVGA, 1'b0, PCLK_M_SVGA, PCLK_D_SVGA);
			mode_xga: e = make_expect(H_PIX_XGA, H_FP_XGA, H_SW_XGA, H_BP_XGA,
				V_PIX_XGA, V_FP_XGA, V_SW_XGA, V_BP_XGA, 1'b1, PCLK_M_XGA, PCLK_D_XGA);
			mode_sxga: e = make_expect(H_PIX_SXGA, H_FP_SXGA, H_SW_SXGA, H_BP_SXGA,
				V_PIX_SXGA, V_FP_SXGA, V_SW_SXGA, V_BP_SXGA, 1'b0, PCLK_M_SXGA, PCLK_D_SXGA);
			mode_camera: e = make_expect(H_PIX_CAMERA, H_FP_CAMERA, H_SW_CAMERA, H_BP_CAMERA,
				V_PIX_CAMERA, V_FP_CAMERA, V_SW_CAMERA, V_BP_CAMERA, 1'b0,
				PCLK_M_CAMERA, PCLK_D_CAMERA);
			default: e = make_expect(H_PIX_HD720, H_FP_HD720, H_SW_HD720, H_BP_HD720,
				V_PIX_HD720, V_FP_HD720, V_SW_HD720, V_BP_HD720, 1'b0,
				PCLK_M_HD720, PCLK_D_HD720); // Unused codes fall back to 720p
		endcase
		return e;
	endfunction

	////////////////////
	// Checkers
	////////////////////
	always @(posedge clk50m_bufg) begin
		cycles <= cycles + 1;
		if (!rst_n)
			rst_cycles <= rst_cycles + 1;
		if (prog_go)
			go_count <= go_count + 1;
		if (hs_per_done)
			line_count <= line_count + 1;
		if (vs_per_done)
			frame_count <= frame_count + 1;
		if (cycles >= TIMEOUT_CYCLES)
			fail_run($sformatf("Timeout, run still going after %0d cycles", cycles));
	end

	// Outputs quiet once reset has been seen
	assert property (@(posedge clk50m_bufg) (!rst_n && rst_cycles > 1) |->
		(!video.de && !prog_go && !video.hsync && !video.vsync))
		else fail_run("de, prog_go or a sync output active during reset");
	assert property (@(posedge clk50m_bufg)
		(rst_cycles > 1 && (!rst_n || !hold_checks || prog_go)) |->
		(clk_cfg == {want.m, want.d}))
		else report_mismatch("clk_cfg", 32'($sampled(clk_cfg)), 32'({want.m, want.d}));
	assert property (@(posedge clk50m_bufg) prog_go |-> (go_count < exp_gos))
		else fail_run("prog_go pulsed without a new accepted switch code");
	assert property (@(posedge clk50m_bufg) (de_done && !hold_checks) |-> (de_width == want.pix))
		else report_mismatch("de_width", $sampled(de_width), want.pix);
	assert property (@(posedge clk50m_bufg) (hs_done && !hold_checks) |-> (hs_width == want.hsw))
		else report_mismatch("hsync_width", $sampled(hs_width), want.hsw);
	assert property (@(posedge clk50m_bufg)
		(hs_per_done && !hold_checks) |-> (hs_period == want.htotal))
		else report_mismatch("hsync_period", $sampled(hs_period), want.htotal);
	assert property (@(posedge clk50m_bufg)
		(vs_done && !hold_checks) |-> (vs_width == want.vsw * want.htotal))
		else report_mismatch("vsync_width", $sampled(vs_width), want.vsw * want.htotal);
	assert property (@(posedge clk50m_bufg)
		(vs_per_done && !hold_checks) |-> (vs_period == want.vtotal * want.htotal))
		else report_mismatch("vsync_period", $sampled(vs_period), want.vtotal * want.htotal);

	////////////////////
	// Stimulus
	////////////////////
	task automatic wait_for_go();
		while (go_count < exp_gos)
			@(posedge clk50m_bufg);
		@(negedge clk50m_bufg);
		hold_checks = 1'b0; // Raster restarted with the load
	endtask

	task automatic change_mode(input logic [3:0] code);
		@(negedge clk50m_bufg);
		hold_checks = 1'b1;
		sw          = code;
		want        = expect_for(code);
		exp_gos     = exp_gos + 1;
		wait_for_go();
	endtask

	task automatic run_lines(input int n);
		int target;
		target = line_count + n;
		while (line_count < target)
			@(posedge clk50m_bufg);
	endtask

	task automatic run_frames(input int n);
		int target;
		target = frame_count + n;
		while (frame_count < target)
			@(posedge clk50m_bufg);
	endtask

	initial begin
		void'($urandom(32'h682198db));
		clk50m_bufg = 1'b0;
		rst_n       = 1'b0;
		sw          = mode_hd720;
		hold_checks = 1'b1;
		want        = expect_for(mode_hd720);
		repeat (5) @(negedge clk50m_bufg);
		rst_n   = 1'b1;
		exp_gos = 1; // First stable code is always taken
		wait_for_go();
		run_lines(4);

		change_mode(mode_vga);
		run_lines(4);
		run_frames(1); // Vsync width and frame length

		// Short glitches must not reload
		repeat (3) begin
			@(negedge clk50m_bufg);
			glitch_len  = 1 + int'($urandom % (DEBOUNCE_CYCLES - 16));
			glitch_code = 4'(1 + ($urandom % 15));
			sw          = glitch_code;
			repeat (glitch_len) @(negedge clk50m_bufg);
			sw = mode_vga;
			repeat (DEBOUNCE_CYCLES + PROG_GO_DELAY + 8) @(negedge clk50m_bufg);
		end
		run_lines(4);

		change_mode(4'b0101); // Unused code
		run_lines(4);
		change_mode(mode_sxga);
		run_lines(4);
		change_mode(mode_camera);
		run_lines(4);

		$display("Verification passed");
		$finish;
	end

endmodule

// File: vlog.f
source/video_pkg.sv
source/mode_switch_debounce.sv
source/mode_control.sv
source/timing_table.sv
source/raster_timing.sv
source/video_mode_top.sv
verif/tb_video_mode.sv
